// ==== include/tlu_defines.svh ====
`ifndef TLU_DEFINES_SVH
`define TLU_DEFINES_SVH

// widths
`define TLU_TRG_WIDTH    8
`define TLU_ABUS_WIDTH   16
`define TLU_DATA_WIDTH   8
`define TLU_COUNT_WIDTH  32
`define TLU_WORD_WIDTH   32
`define TLU_LOST_WIDTH   8

`define TLU_VERSION      11
`define TLU_FIFO_DEPTH   8     // output fifo words

// register map, byte wide
`define TLU_ADDR_RESET     0   // write resets, read gives version
`define TLU_ADDR_CONF      1   // bit 0 enable, bit 1 external ack
`define TLU_ADDR_TRG_SEL   2
`define TLU_ADDR_VETO_SEL  3
`define TLU_ADDR_TRG_INV   4
`define TLU_ADDR_CNT       8   // 8 to 11, low byte first
`define TLU_ADDR_CNT_MAX   12  // 12 to 15
`define TLU_ADDR_LOST      16
`define TLU_ADDR_SOFT_TRG  17

`endif

// ==== hw/tlu_pkg.sv ====
`include "tlu_defines.svh"

package tlu_pkg;

    typedef logic [`TLU_ABUS_WIDTH-1:0]  bus_addr_t;
    typedef logic [`TLU_DATA_WIDTH-1:0]  bus_data_t;
    typedef logic [`TLU_TRG_WIDTH-1:0]   trg_mask_t;   // one bit per input
    typedef logic [`TLU_COUNT_WIDTH-1:0] trg_count_t;
    typedef logic [`TLU_WORD_WIDTH-1:0]  trg_word_t;   // msb marks a trigger word
    typedef logic [`TLU_LOST_WIDTH-1:0]  lost_count_t;

    // everything the bus can configure
    typedef struct packed {
        logic       trigger_enable;
        logic       ext_ack_enable;
        trg_mask_t  trigger_select;
        trg_mask_t  veto_select;
        trg_mask_t  trigger_invert;
        trg_count_t count_max;      // 0 disables the limit
    } tlu_conf_t;

    typedef enum logic [1:0] {
        idle,
        req_high,
        wait_ack_low
    } fsm_state_t;

endpackage

// ==== hw/tlu_regs.sv ====
`include "tlu_defines.svh"

module tlu_regs (
    input  logic                BUS_CLK,
    input  logic                RST,
    input  tlu_pkg::bus_addr_t  BUS_ADD,
    input  tlu_pkg::bus_data_t  BUS_DATA_IN,
    input  logic                BUS_RD,
    input  logic                BUS_WR,
    output tlu_pkg::bus_data_t  BUS_DATA_OUT,
    input  tlu_pkg::trg_count_t trg_count,
    input  tlu_pkg::lost_count_t lost_count,
    output tlu_pkg::tlu_conf_t  conf,
    output logic                soft_trigger,
    output logic                soft_rst
);

    logic                rst_int;
    tlu_pkg::trg_count_t count_buf;   // upper bytes of the count seen at the last read of 8

    // strobes straight from the bus, one cycle per write
    assign soft_rst     = BUS_WR && (BUS_ADD == `TLU_ADDR_RESET);
    assign soft_trigger = BUS_WR && (BUS_ADD == `TLU_ADDR_SOFT_TRG);

    assign rst_int = RST | soft_rst;

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_int)
        begin
            conf <= '0;
        end
        else if (BUS_WR)
        begin
            case (BUS_ADD)
                `TLU_ADDR_CONF:
                begin
                    conf.trigger_enable <= BUS_DATA_IN[0];
                    conf.ext_ack_enable <= BUS_DATA_IN[1];
                end
                `TLU_ADDR_TRG_SEL:      conf.trigger_select  <= BUS_DATA_IN;
                `TLU_ADDR_VETO_SEL:     conf.veto_select     <= BUS_DATA_IN;
                `TLU_ADDR_TRG_INV:      conf.trigger_invert  <= BUS_DATA_IN;
                `TLU_ADDR_CNT_MAX:      conf.count_max[7:0]   <= BUS_DATA_IN;
                `TLU_ADDR_CNT_MAX + 1:  conf.count_max[15:8]  <= BUS_DATA_IN;
                `TLU_ADDR_CNT_MAX + 2:  conf.count_max[23:16] <= BUS_DATA_IN;
                `TLU_ADDR_CNT_MAX + 3:  conf.count_max[31:24] <= BUS_DATA_IN;
                default:
                begin
                    conf <= conf;   // read-only or strobe address
                end
            endcase
        end
    end

    // reading the low byte freezes the rest for a coherent 32 bit value
    always_ff @(posedge BUS_CLK)
    begin
        if (rst_int)
        begin
            count_buf <= '0;
        end
        else if (BUS_RD && (BUS_ADD == `TLU_ADDR_CNT))
        begin
            count_buf <= trg_count;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (BUS_RD)
        begin
            case (BUS_ADD)
                `TLU_ADDR_RESET:        BUS_DATA_OUT <= tlu_pkg::bus_data_t'(`TLU_VERSION);
                `TLU_ADDR_CONF:
                begin
                    BUS_DATA_OUT <= {6'b0, conf.ext_ack_enable, conf.trigger_enable};
                end
                `TLU_ADDR_TRG_SEL:      BUS_DATA_OUT <= conf.trigger_select;
                `TLU_ADDR_VETO_SEL:     BUS_DATA_OUT <= conf.veto_select;
                `TLU_ADDR_TRG_INV:      BUS_DATA_OUT <= conf.trigger_invert;
                `TLU_ADDR_CNT:          BUS_DATA_OUT <= trg_count[7:0];   // live value
                `TLU_ADDR_CNT + 1:      BUS_DATA_OUT <= count_buf[15:8];
                `TLU_ADDR_CNT + 2:      BUS_DATA_OUT <= count_buf[23:16];
                `TLU_ADDR_CNT + 3:      BUS_DATA_OUT <= count_buf[31:24];
                `TLU_ADDR_CNT_MAX:      BUS_DATA_OUT <= conf.count_max[7:0];
                `TLU_ADDR_CNT_MAX + 1:  BUS_DATA_OUT <= conf.count_max[15:8];
                `TLU_ADDR_CNT_MAX + 2:  BUS_DATA_OUT <= conf.count_max[23:16];
                `TLU_ADDR_CNT_MAX + 3:  BUS_DATA_OUT <= conf.count_max[31:24];
                `TLU_ADDR_LOST:         BUS_DATA_OUT <= lost_count;
                default:                BUS_DATA_OUT <= '0;
            endcase
        end
    end

endmodule

// ==== hw/trigger_input.sv ====
module trigger_input (
    input  logic                BUS_CLK,
    input  logic                RST,
    input  tlu_pkg::trg_mask_t  trigger,
    input  tlu_pkg::trg_mask_t  trigger_veto,
    input  logic                soft_trigger,
    input  tlu_pkg::tlu_conf_t  conf,
    output logic                trg_edge,
    output logic                veto
);

    tlu_pkg::trg_mask_t trg_masked;
    logic               trg_or;
    logic               veto_or;
    logic [1:0]         trg_sync;    // [1] is the synchronized level
    logic [1:0]         veto_sync;
    logic               trg_prev;

    // combine before synchronizing so only one bit crosses
    assign trg_masked = (trigger ^ conf.trigger_invert) & conf.trigger_select;
    assign trg_or     = |trg_masked;
    assign veto_or    = |(trigger_veto & conf.veto_select);

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trg_sync  <= '0;
            veto_sync <= '0;
            trg_prev  <= 1'b0;
            trg_edge  <= 1'b0;
        end
        else
        begin
            trg_sync  <= {trg_sync[0], trg_or};
            veto_sync <= {veto_sync[0], veto_or};
            trg_prev  <= trg_sync[1];
            // rising edge, or a bus write to the soft trigger address
            trg_edge  <= (trg_sync[1] & ~trg_prev) | soft_trigger;
        end
    end

    assign veto = veto_sync[1];   // one cycle ahead of the matching edge

endmodule

// ==== hw/trigger_fsm.sv ====
module trigger_fsm (
    input  logic                BUS_CLK,
    input  logic                RST,
    input  tlu_pkg::tlu_conf_t  conf,
    input  logic                trg_edge,
    input  logic                veto,
    input  logic                trigger_ack,
    output logic                trigger_req,
    output tlu_pkg::trg_count_t trg_count,
    output logic                push,
    output tlu_pkg::trg_word_t  word
);

    tlu_pkg::fsm_state_t state;
    tlu_pkg::fsm_state_t state_next;
    logic                self_ack;    // req delayed by one cycle
    logic                ack;
    logic                limit_reached;
    logic                accept;

    assign ack = conf.ext_ack_enable ? trigger_ack : self_ack;

    assign limit_reached = (conf.count_max != '0) && (trg_count >= conf.count_max);

    // ack must be low too, so req never rises into a stale ack
    assign accept = (state == tlu_pkg::idle) && trg_edge && conf.trigger_enable
                    && !veto && !limit_reached && !ack;

    always_comb
    begin
        state_next = state;
        case (state)
            tlu_pkg::idle:
            begin
                if (accept)
                begin
                    state_next = tlu_pkg::req_high;
                end
            end
            tlu_pkg::req_high:
            begin
                if (ack)
                begin
                    state_next = tlu_pkg::wait_ack_low;
                end
            end
            tlu_pkg::wait_ack_low:
            begin
                if (!ack)
                begin
                    state_next = tlu_pkg::idle;
                end
            end
            default:
            begin
                state_next = tlu_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            state    <= tlu_pkg::idle;
            self_ack <= 1'b0;
        end
        else
        begin
            state    <= state_next;
            self_ack <= trigger_req;
        end
    end

    assign trigger_req = (state == tlu_pkg::req_high);   // straight from the state flops

    // word goes out the cycle ack is first seen high
    assign push = trigger_req && ack;
    assign word = {1'b1, trg_count[30:0]};   // zero based trigger number

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trg_count <= '0;
        end
        else if (push)
        begin
            trg_count <= trg_count + 1'b1;   // counted even if the fifo drops it
        end
    end

endmodule

// ==== hw/trigger_fifo.sv ====
`include "tlu_defines.svh"

module trigger_fifo (
    input  logic                 BUS_CLK,
    input  logic                 RST,
    input  logic                 push,
    input  tlu_pkg::trg_word_t   word,
    input  logic                 pop,
    output logic                 empty,
    output tlu_pkg::trg_word_t   data,
    output tlu_pkg::lost_count_t lost_count
);

    localparam int DEPTH = `TLU_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int OCC_W = $clog2(DEPTH + 1);

    tlu_pkg::trg_word_t mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [OCC_W-1:0]   occupancy;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full    = (occupancy == OCC_W'(DEPTH));
    assign empty   = (occupancy == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign data    = mem[rd_ptr];   // head word, valid while not empty

    always_ff @(posedge BUS_CLK)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= word;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            occupancy <= occupancy + OCC_W'(do_push) - OCC_W'(do_pop);
        end
    end

    // words pushed into a full fifo, stops at all ones
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            lost_count <= '0;
        end
        else if (push && full && (lost_count != '1))
        begin
            lost_count <= lost_count + 1'b1;
        end
    end

endmodule

// ==== hw/tlu_core.sv ====
module tlu_core (
    input  logic                BUS_CLK,
    input  logic                RST,
    input  tlu_pkg::bus_addr_t  BUS_ADD,
    input  tlu_pkg::bus_data_t  BUS_DATA_IN,
    input  logic                BUS_RD,
    input  logic                BUS_WR,
    output tlu_pkg::bus_data_t  BUS_DATA_OUT,
    input  tlu_pkg::trg_mask_t  TRIGGER,
    input  tlu_pkg::trg_mask_t  TRIGGER_VETO,
    input  logic                TRIGGER_ACK,
    output logic                TRIGGER_REQ,
    output logic                TRIGGER_ENABLED,
    input  logic                FIFO_READ,
    output logic                FIFO_EMPTY,
    output tlu_pkg::trg_word_t  FIFO_DATA
);

    tlu_pkg::tlu_conf_t   conf;
    tlu_pkg::trg_count_t  trg_count;
    tlu_pkg::lost_count_t lost_count;
    tlu_pkg::trg_word_t   word;
    logic                 soft_trigger;
    logic                 soft_rst;
    logic                 rst_int;
    logic                 trg_edge;
    logic                 veto;
    logic                 push;

    assign rst_int         = RST | soft_rst;   // bus reset or write to address 0
    assign TRIGGER_ENABLED = conf.trigger_enable;

    tlu_regs u_regs (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .BUS_ADD      (BUS_ADD),
        .BUS_DATA_IN  (BUS_DATA_IN),
        .BUS_RD       (BUS_RD),
        .BUS_WR       (BUS_WR),
        .BUS_DATA_OUT (BUS_DATA_OUT),
        .trg_count    (trg_count),
        .lost_count   (lost_count),
        .conf         (conf),
        .soft_trigger (soft_trigger),
        .soft_rst     (soft_rst)
    );

    trigger_input u_input (
        .BUS_CLK      (BUS_CLK),
        .RST          (rst_int),
        .trigger      (TRIGGER),
        .trigger_veto (TRIGGER_VETO),
        .soft_trigger (soft_trigger),
        .conf         (conf),
        .trg_edge     (trg_edge),
        .veto         (veto)
    );

    trigger_fsm u_fsm (
        .BUS_CLK      (BUS_CLK),
        .RST          (rst_int),
        .conf         (conf),
        .trg_edge     (trg_edge),
        .veto         (veto),
        .trigger_ack  (TRIGGER_ACK),
        .trigger_req  (TRIGGER_REQ),
        .trg_count    (trg_count),
        .push         (push),
        .word         (word)
    );

    trigger_fifo u_fifo (
        .BUS_CLK      (BUS_CLK),
        .RST          (rst_int),
        .push         (push),
        .word         (word),
        .pop          (FIFO_READ),
        .empty        (FIFO_EMPTY),
        .data         (FIFO_DATA),
        .lost_count   (lost_count)
    );

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic BUS_CLK
);

    initial
    begin
        BUS_CLK = 1'b0;
        forever #(PERIOD / 2) BUS_CLK = ~BUS_CLK;
    end

endmodule

// ==== testbench/tlu_props.sv ====
`include "tlu_defines.svh"

module tlu_props #(
    parameter int OCC_W = $clog2(`TLU_FIFO_DEPTH + 1)
) (
    input logic             BUS_CLK,
    input logic             RST,
    input logic             req,
    input logic             ack,
    input logic [OCC_W-1:0] occupancy
);

    // four phase handshake as the fsm sees it
    req_holds: assert property (@(posedge BUS_CLK) disable iff (RST) req && !ack |=> req)
        else $error("req dropped before ack");

    req_no_rise: assert property (@(posedge BUS_CLK) disable iff (RST) !req && ack |=> !req)
        else $error("req rose while ack was high");

    occ_range: assert property (@(posedge BUS_CLK) disable iff (RST)
        occupancy <= OCC_W'(`TLU_FIFO_DEPTH))
        else $error("fifo occupancy above depth");

endmodule

// handshake checks only, occupancy unused here
bind trigger_fsm tlu_props u_hs_props (
    .BUS_CLK   (BUS_CLK),
    .RST       (RST),
    .req       (trigger_req),
    .ack       (ack),
    .occupancy ('0)
);

bind trigger_fifo tlu_props u_occ_props (
    .BUS_CLK   (BUS_CLK),
    .RST       (RST),
    .req       (1'b0),
    .ack       (1'b0),
    .occupancy (occupancy)
);

// ==== testbench/tb_tlu_core.sv ====
`include "tlu_defines.svh"

module tb_tlu_core;

    localparam int SETTLE  = 12;                    // one self-acked trigger, edge to idle
    localparam int PLANNED = 5 + 48 + 6 + 8 + 12;   // triggers over all tests
    localparam int TIMEOUT = 200 * PLANNED + 1000;

    logic                 BUS_CLK;
    logic                 RST;
    tlu_pkg::bus_addr_t   bus_add;
    tlu_pkg::bus_data_t   bus_data_in;
    logic                 bus_rd;
    logic                 bus_wr;
    tlu_pkg::bus_data_t   bus_data_out;
    tlu_pkg::trg_mask_t   trigger;
    tlu_pkg::trg_mask_t   trigger_veto;
    logic                 trigger_ack;
    logic                 trigger_req;
    logic                 trigger_enabled;
    logic                 fifo_read;
    logic                 fifo_empty;
    tlu_pkg::trg_word_t   fifo_data;

    logic [31:0]          rng_state = 32'd25;
    logic [31:0]          exp_q[$];            // words still owed by the fifo
    logic [31:0]          model_count = '0;
    logic [31:0]          model_lost = '0;
    logic [31:0]          model_max = '0;
    logic                 model_enable = 1'b0;
    logic                 drain_en = 1'b1;
    tlu_pkg::trg_mask_t   sel_m = '0;
    tlu_pkg::trg_mask_t   inv_m = '0;
    tlu_pkg::trg_mask_t   vsel_m = '0;

    tb_clock #(.PERIOD(4)) u_clock (.BUS_CLK(BUS_CLK));

    tlu_core u_tlu_core (
        .BUS_CLK         (BUS_CLK),
        .RST             (RST),
        .BUS_ADD         (bus_add),
        .BUS_DATA_IN     (bus_data_in),
        .BUS_RD          (bus_rd),
        .BUS_WR          (bus_wr),
        .BUS_DATA_OUT    (bus_data_out),
        .TRIGGER         (trigger),
        .TRIGGER_VETO    (trigger_veto),
        .TRIGGER_ACK     (trigger_ack),
        .TRIGGER_REQ     (trigger_req),
        .TRIGGER_ENABLED (trigger_enabled),
        .FIFO_READ       (fifo_read),
        .FIFO_EMPTY      (fifo_empty),
        .FIFO_DATA       (fifo_data)
    );

    function automatic logic [31:0] xorshift_next();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // n-th accepted trigger, zero based, marker in the msb
    function automatic logic [31:0] expected_word(input logic [31:0] n);
        return {1'b1, n[30:0]};
    endfunction

    function automatic logic combined(input tlu_pkg::trg_mask_t in,
                                      input tlu_pkg::trg_mask_t inv,
                                      input tlu_pkg::trg_mask_t sel);
        return |((in ^ inv) & sel);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic bus_write(input int addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add     <= tlu_pkg::bus_addr_t'(addr);
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr      <= 1'b0;
    endtask

    task automatic bus_read(input int addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add <= tlu_pkg::bus_addr_t'(addr);
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd  <= 1'b0;
        @(negedge BUS_CLK);   // registered read data settled
        data = bus_data_out;
    endtask

    task automatic write_readback(input int addr, input logic [7:0] data);
        logic [7:0] rd;
        bus_write(addr, data);
        bus_read(addr, rd);
        check_value($sformatf("register %0d", addr), rd, data);
    endtask

    task automatic check_count();
        logic [7:0]  b;
        logic [31:0] count;
        for (int i = 0; i < 4; i++)
        begin
            bus_read(`TLU_ADDR_CNT + i, b);   // low byte first latches the rest
            count[8*i +: 8] = b;
        end
        check_value("trigger count", count, model_count);
    endtask

    task automatic write_conf(input logic [7:0] value);
        bus_write(`TLU_ADDR_CONF, value);
        model_enable = value[0];
    endtask

    task automatic soft_reset();
        bus_write(`TLU_ADDR_RESET, 8'h00);
        model_count  = '0;
        model_lost   = '0;
        model_max    = '0;
        model_enable = 1'b0;
        sel_m        = '0;
        inv_m        = '0;
        vsel_m       = '0;
    endtask

    // one edge reaching an idle fsm
    task automatic model_trigger();
        if (model_enable && (model_max == 0 || model_count < model_max))
        begin
            if (exp_q.size() < `TLU_FIFO_DEPTH)
                exp_q.push_back(expected_word(model_count));
            else
                model_lost++;
            model_count++;   // counted even when dropped
        end
    endtask

    task automatic fire_soft_trigger();
        model_trigger();
        bus_write(`TLU_ADDR_SOFT_TRG, 8'h00);
        repeat (SETTLE) @(posedge BUS_CLK);
    endtask

    task automatic answer_request();
        int delay;
        do @(negedge BUS_CLK); while (!trigger_req);
        delay = int'(xorshift_next() & 32'd7);
        repeat (delay + 1) @(posedge BUS_CLK);
        trigger_ack <= 1'b1;
        do @(negedge BUS_CLK); while (trigger_req);
        delay = int'(xorshift_next() & 32'd7);
        repeat (delay + 1) @(posedge BUS_CLK);
        trigger_ack <= 1'b0;
        repeat (4) @(posedge BUS_CLK);   // back to idle
    endtask

    task automatic set_masks(input tlu_pkg::trg_mask_t sel, input tlu_pkg::trg_mask_t inv,
                             input tlu_pkg::trg_mask_t vsel);
        write_conf(8'h00);   // mask changes may make edges of their own
        bus_write(`TLU_ADDR_TRG_SEL, sel);
        bus_write(`TLU_ADDR_TRG_INV, inv);
        bus_write(`TLU_ADDR_VETO_SEL, vsel);
        sel_m  = sel;
        inv_m  = inv;
        vsel_m = vsel;
        repeat (SETTLE) @(posedge BUS_CLK);
        write_conf(8'h01);
    endtask

    task automatic apply_pattern(input tlu_pkg::trg_mask_t trg, input tlu_pkg::trg_mask_t vto);
        logic was_high;
        was_high = combined(trigger, inv_m, sel_m);
        @(posedge BUS_CLK);
        trigger      <= trg;
        trigger_veto <= vto;
        if (!was_high && combined(trg, inv_m, sel_m) && !combined(vto, '0, vsel_m))
            model_trigger();
        repeat (SETTLE) @(posedge BUS_CLK);
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge BUS_CLK);
            cycles++;
            if (cycles > 200)
                report_failure("expected fifo words never arrived");
        end
        while (exp_q.size() != 0 || !fifo_empty);
    endtask

    // pops every word and compares it with the model queue
    initial
    begin
        fifo_read = 1'b0;
        forever
        begin
            @(negedge BUS_CLK);
            if (drain_en && !fifo_empty)
            begin
                if (exp_q.size() == 0)
                    report_failure($sformatf("fifo word %h appeared at %0t, none expected",
                                             fifo_data, $time));
                check_value("FIFO_DATA", fifo_data, exp_q.pop_front());
                @(posedge BUS_CLK);
                fifo_read <= 1'b1;
                @(posedge BUS_CLK);
                fifo_read <= 1'b0;
            end
        end
    end

    initial
    begin
        repeat (TIMEOUT) @(posedge BUS_CLK);
        report_failure("timeout, the tests did not finish in time");
    end

    initial
    begin
        logic [7:0]  rd;
        logic [31:0] r;
        logic [31:0] s;
        RST          = 1'b1;
        bus_add      = '0;
        bus_data_in  = '0;
        bus_rd       = 1'b0;
        bus_wr       = 1'b0;
        trigger      = '0;
        trigger_veto = '0;
        trigger_ack  = 1'b0;
        repeat (3) @(posedge BUS_CLK);
        RST <= 1'b0;
        @(negedge BUS_CLK);
        check_value("TRIGGER_REQ", trigger_req, 32'd0);
        check_value("FIFO_EMPTY", fifo_empty, 32'd1);
        check_value("TRIGGER_ENABLED", trigger_enabled, 32'd0);

        // register map
        bus_read(`TLU_ADDR_RESET, rd);
        check_value("version", rd, `TLU_VERSION);
        write_readback(`TLU_ADDR_TRG_SEL, 8'h3c);
        write_readback(`TLU_ADDR_VETO_SEL, 8'h81);
        write_readback(`TLU_ADDR_TRG_INV, 8'h5a);
        write_readback(`TLU_ADDR_CNT_MAX + 2, 8'h7e);
        write_readback(`TLU_ADDR_CONF, 8'h02);
        bus_read(5, rd);
        check_value("unmapped register", rd, 32'd0);

        soft_reset();
        write_conf(8'h01);
        @(negedge BUS_CLK);
        check_value("TRIGGER_ENABLED", trigger_enabled, 32'd1);
        repeat (5) fire_soft_trigger();
        wait_drained();
        check_count();

        // random masks and patterns, self ack
        soft_reset();
        repeat (4)
        begin
            r = xorshift_next();
            s = xorshift_next();
            set_masks(r[7:0] & r[15:8], r[23:16], s[7:0] & s[15:8] & s[23:16]);
            repeat (12)
            begin
                r = xorshift_next();
                apply_pattern(r[7:0], r[15:8]);
            end
        end
        wait_drained();
        check_count();

        // external ack with random delays
        soft_reset();
        write_conf(8'h03);
        repeat (6)
        begin
            model_trigger();
            bus_write(`TLU_ADDR_SOFT_TRG, 8'h00);
            answer_request();
        end
        wait_drained();
        check_count();

        soft_reset();
        bus_write(`TLU_ADDR_CNT_MAX, 8'd5);
        model_max = 5;
        write_conf(8'h01);
        repeat (8) fire_soft_trigger();
        wait_drained();
        check_count();

        // fifo overflow without reads
        soft_reset();
        write_conf(8'h01);
        drain_en = 1'b0;
        repeat (12) fire_soft_trigger();
        bus_read(`TLU_ADDR_LOST, rd);
        check_value("lost count", rd, model_lost);
        check_count();
        drain_en = 1'b1;
        wait_drained();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
hw/tlu_pkg.sv
hw/tlu_regs.sv
hw/trigger_input.sv
hw/trigger_fsm.sv
hw/trigger_fifo.sv
hw/tlu_core.sv
testbench/tb_clock.sv
testbench/tlu_props.sv
testbench/tb_tlu_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_tlu_core -f sources.f &&
./obj_dir/Vtb_tlu_core || exit 1
